// ==== epb_config.svh ====
`ifndef EPB_CONFIG_SVH
`define EPB_CONFIG_SVH

// slave groups, taken from the EPB general purpose address bits
// register bank answers on group 0
`define EPB_GP_REGBANK 6'd0
// board identification block
`define EPB_GP_IDBLOCK 6'd1

// log2 of the register bank depth in 16-bit words
`define REG_BANK_ADDR_BITS 4

// constants returned by the ID block
// word 0
`define BOARD_ID 16'hb2a0
// word 1, major in the upper byte and minor in the lower byte
`define FW_REVISION 16'h0103

`endif

// ==== epb_pkg.sv ====
package epb_pkg;

  // word address as the EPB master drives it
  typedef logic [22:0] epb_addr_t;

  // general purpose address extension, selects the slave group
  typedef logic [5:0] epb_gp_t;

  // EPB data bus
  typedef logic [15:0] epb_data_t;

  // byte enables, active low
  // bit 0 is the low byte
  typedef logic [1:0] epb_be_t;

  // command as presented by the master while chip select is low
  typedef struct packed {
    // high for a read
    logic      rd_wr_n;
    epb_be_t   be_n;
    epb_gp_t   gp;
    epb_addr_t addr;
    // write data, ignored on reads
    epb_data_t data;
  } epb_cmd_t;

endpackage

// ==== wb_pkg.sv ====
package wb_pkg;

  // byte address on the Wishbone side
  typedef logic [31:0] wb_adr_t;

  // 16-bit data path
  typedef logic [15:0] wb_dat_t;

  // one select bit per byte lane
  typedef logic [1:0] wb_sel_t;

  // master to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_sel_t sel;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_req_t;

  // slave to master
  // ack and err are one-cycle pulses, never both at once
  typedef struct packed {
    logic    ack;
    logic    err;
    wb_dat_t dat;
  } wb_rsp_t;

endpackage

// ==== epb_wb_bridge_reg.sv ====
`timescale 1ns/1ps

module epb_wb_bridge_reg (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               epb_clk_i,
  input  logic               epb_cs_n_i,
  input  epb_pkg::epb_cmd_t  epb_cmd_i,
  output wb_pkg::wb_req_t    wb_req_o,
  input  wb_pkg::wb_rsp_t    wb_rsp_i,
  output epb_pkg::epb_data_t epb_data_o,
  output logic               epb_rdy_o
);

  // EPB domain
  logic              prev_cs_n;
  logic              cs_fall;
  logic              cmnd_pend;
  logic              cmnd_got_reg;
  logic              cmnd_ack_meta;
  logic              cmnd_ack;
  logic              resp_got_meta;
  logic              resp_got;
  epb_pkg::epb_cmd_t cmd_q;

  // Wishbone domain
  logic              cmnd_got_meta;
  logic              cmnd_got;
  logic              cmnd_ack_reg;
  logic              wb_cyc;
  logic              resp_pend;
  logic              resp_got_reg;
  logic              resp_ack_meta;
  logic              resp_ack;
  logic              epb_rdy_q;
  wb_pkg::wb_dat_t   rd_data_q;

  // chip select just went low
  assign cs_fall = prev_cs_n & ~epb_cs_n_i;

  // command capture, master holds the fields stable for the transfer
  always_ff @(posedge epb_clk_i) begin
    if (cs_fall) begin
      cmd_q <= epb_cmd_i;
    end
  end

  // command flag, raised only while the ack of the last one is low
  // so a quick second transfer waits in cmnd_pend instead of being lost
  always_ff @(posedge epb_clk_i) begin
    if (wb_rst_i) begin
      prev_cs_n    <= 1'b1;
      cmnd_pend    <= 1'b0;
      cmnd_got_reg <= 1'b0;
    end else begin
      prev_cs_n <= epb_cs_n_i;
      if (!cmnd_ack && (cs_fall || cmnd_pend)) begin
        cmnd_got_reg <= 1'b1;
        cmnd_pend    <= 1'b0;
      end else begin
        if (cs_fall) begin
          cmnd_pend <= 1'b1;
        end
        if (cmnd_ack) begin
          cmnd_got_reg <= 1'b0;
        end
      end
    end
  end

  // into the EPB domain: command ack and response flag
  always_ff @(posedge epb_clk_i) begin
    if (wb_rst_i) begin
      cmnd_ack_meta <= 1'b0;
      cmnd_ack      <= 1'b0;
      resp_got_meta <= 1'b0;
      resp_got      <= 1'b0;
    end else begin
      cmnd_ack_meta <= cmnd_ack_reg;
      cmnd_ack      <= cmnd_ack_meta;
      resp_got_meta <= resp_got_reg;
      resp_got      <= resp_got_meta;
    end
  end

  // into the Wishbone domain: command flag and response ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cmnd_got_meta <= 1'b0;
      cmnd_got      <= 1'b0;
      resp_ack_meta <= 1'b0;
      resp_ack      <= 1'b0;
    end else begin
      cmnd_got_meta <= cmnd_got_reg;
      cmnd_got      <= cmnd_got_meta;
      resp_ack_meta <= resp_got;
      resp_ack      <= resp_ack_meta;
    end
  end

  // single strobe on the first cycle the synchronized flag is seen
  // cmnd_ack_reg doubles as the ack sent back to the EPB side
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cmnd_ack_reg <= 1'b0;
      wb_cyc       <= 1'b0;
    end else begin
      cmnd_ack_reg <= cmnd_got;
      wb_cyc       <= cmnd_got & ~cmnd_ack_reg;
    end
  end

  // response flag, set by ack or err and held until the EPB side has seen it
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      resp_pend    <= 1'b0;
      resp_got_reg <= 1'b0;
    end else begin
      if (!resp_ack && (wb_rsp_i.ack || wb_rsp_i.err || resp_pend)) begin
        resp_got_reg <= 1'b1;
        resp_pend    <= 1'b0;
      end else begin
        if (wb_rsp_i.ack || wb_rsp_i.err) begin
          resp_pend <= 1'b1;
        end
        if (resp_ack) begin
          resp_got_reg <= 1'b0;
        end
      end
    end
  end

  // ready drops as soon as a new chip select is seen
  // it rises once, on the first cycle the returned response shows up
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      epb_rdy_q <= 1'b0;
    end else begin
      if (cs_fall || cmnd_pend) begin
        epb_rdy_q <= 1'b0;
      end
      if (resp_ack_meta && !resp_ack) begin
        epb_rdy_q <= 1'b1;
      end
    end
  end

  // read data only, an err or a write leaves the last value in place
  always_ff @(posedge wb_clk_i) begin
    if (wb_rsp_i.ack && cmd_q.rd_wr_n) begin
      rd_data_q <= wb_rsp_i.dat;
    end
  end

  assign wb_req_o.cyc = wb_cyc;
  assign wb_req_o.stb = wb_cyc;
  assign wb_req_o.we  = ~cmd_q.rd_wr_n;
  assign wb_req_o.sel = ~cmd_q.be_n;
  // word address to byte address, gp lands in bits 29:24
  assign wb_req_o.adr = {2'b00, cmd_q.gp, cmd_q.addr, 1'b0};
  assign wb_req_o.dat = cmd_q.data;

  assign epb_data_o = rd_data_q;
  assign epb_rdy_o  = epb_rdy_q;

  // one strobe per transfer, never a two-cycle cycle
  a_single_cyc: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) wb_req_o.cyc |=> !wb_req_o.cyc
  );

  // a slave ack must answer the strobe of the cycle before
  a_ack_after_stb: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) wb_rsp_i.ack |-> $past(wb_req_o.stb)
  );

endmodule

// ==== wb_slave_decode.sv ====
`timescale 1ns/1ps
`include "epb_config.svh"

module wb_slave_decode (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_req_t regbank_req_o,
  output wb_pkg::wb_req_t idblock_req_o,
  input  wb_pkg::wb_rsp_t regbank_rsp_i,
  input  wb_pkg::wb_rsp_t idblock_rsp_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  epb_pkg::epb_gp_t group;
  logic             strobe;
  logic             hit_regbank;
  logic             hit_idblock;
  logic             sel_regbank_q;
  logic             sel_idblock_q;
  logic             unmapped_err_q;

  // slave group sits in the byte address just above the EPB word address
  assign group       = req_i.adr[29:24];
  assign strobe      = req_i.cyc & req_i.stb;
  assign hit_regbank = (group == `EPB_GP_REGBANK);
  assign hit_idblock = (group == `EPB_GP_IDBLOCK);

  // every slave sees the request, only the addressed one gets stb
  always_comb begin
    regbank_req_o     = req_i;
    regbank_req_o.stb = strobe & hit_regbank;
    idblock_req_o     = req_i;
    idblock_req_o.stb = strobe & hit_idblock;
  end

  // remember which slave was strobed, its reply comes next cycle
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      sel_regbank_q  <= 1'b0;
      sel_idblock_q  <= 1'b0;
      unmapped_err_q <= 1'b0;
    end else begin
      unmapped_err_q <= strobe & ~hit_regbank & ~hit_idblock;
      if (strobe) begin
        sel_regbank_q <= hit_regbank;
        sel_idblock_q <= hit_idblock;
      end
    end
  end

  // reply mux, unmapped groups answer with our own err
  always_comb begin
    rsp_o = '0;
    if (sel_regbank_q) begin
      rsp_o = regbank_rsp_i;
    end else if (sel_idblock_q) begin
      rsp_o = idblock_rsp_i;
    end
    rsp_o.err = rsp_o.err | unmapped_err_q;
  end

  a_one_slave: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      $onehot0({regbank_req_o.stb, idblock_req_o.stb})
  );

  // whichever slave is hit, a strobe gets exactly one reply one cycle later
  a_reply_next: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) strobe |=> (rsp_o.ack ^ rsp_o.err)
  );

endmodule

// ==== wb_reg_bank.sv ====
`timescale 1ns/1ps
`include "epb_config.svh"

module wb_reg_bank #(
  parameter int ADDR_BITS = `REG_BANK_ADDR_BITS
) (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  localparam int DEPTH = 1 << ADDR_BITS;
  localparam int LANES = $bits(wb_pkg::wb_sel_t);

  wb_pkg::wb_dat_t      mem [DEPTH];
  wb_pkg::wb_dat_t      rd_q;
  logic [ADDR_BITS-1:0] idx;
  logic                 strobe;
  logic                 ack_q;

  assign strobe = req_i.cyc & req_i.stb;
  // word index where higher address bits are ignored so the bank wraps
  assign idx = req_i.adr[ADDR_BITS:1];

  // byte-lane writes land on the same edge that raises ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (strobe && req_i.we) begin
      for (int b = 0; b < LANES; b++) begin
        if (req_i.sel[b]) begin
          mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
  end

  // read word held until the next read
  always_ff @(posedge wb_clk_i) begin
    if (strobe && !req_i.we) begin
      rd_q <= mem[idx];
    end
  end

  // every access is accepted
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= strobe;
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_q};

  // a reply is never both ack and err
  a_reply_ok: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(rsp_o.ack && rsp_o.err)
  );

endmodule

// ==== wb_id_block.sv ====
`timescale 1ns/1ps
`include "epb_config.svh"

module wb_id_block (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  epb_pkg::epb_addr_t word;
  logic               strobe;
  logic               rd_ok;
  logic               ack_q;
  logic               err_q;
  wb_pkg::wb_dat_t    dat_q;
  wb_pkg::wb_dat_t    rej_cnt;

  assign strobe = req_i.cyc & req_i.stb;
  // full word address, no wrap, so word 5 is an error
  assign word = req_i.adr[23:1];
  // read-only block with three words
  assign rd_ok = !req_i.we && (word < 3);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      rej_cnt <= '0;
    end else begin
      ack_q <= strobe & rd_ok;
      err_q <= strobe & ~rd_ok;
      // each write is refused and counted
      if (strobe && req_i.we) begin
        rej_cnt <= rej_cnt + 1'b1;
      end
    end
  end

  // read data, don't care when err is returned
  always_ff @(posedge wb_clk_i) begin
    if (strobe) begin
      case (word)
        23'd0:   dat_q <= `BOARD_ID;
        23'd1:   dat_q <= `FW_REVISION;
        default: dat_q <= rej_cnt;
      endcase
    end
  end

  assign rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

// ==== epb_subsystem_top.sv ====
`timescale 1ns/1ps

module epb_subsystem_top (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               epb_clk_i,
  input  logic               epb_cs_n_i,
  // output enable from the EPB pins, the bridge does not need it
  input  logic               epb_oe_n_i,
  input  epb_pkg::epb_cmd_t  epb_cmd_i,
  output epb_pkg::epb_data_t epb_data_o,
  output logic               epb_rdy_o
);

  // bridge to decoder
  wb_pkg::wb_req_t bridge_req;
  wb_pkg::wb_rsp_t bridge_rsp;

  // decoder to slaves
  wb_pkg::wb_req_t regbank_req;
  wb_pkg::wb_rsp_t regbank_rsp;
  wb_pkg::wb_req_t idblock_req;
  wb_pkg::wb_rsp_t idblock_rsp;

  epb_wb_bridge_reg epb_wb_bridge_reg_i (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .epb_clk_i  (epb_clk_i),
    .epb_cs_n_i (epb_cs_n_i),
    .epb_cmd_i  (epb_cmd_i),
    .wb_req_o   (bridge_req),
    .wb_rsp_i   (bridge_rsp),
    .epb_data_o (epb_data_o),
    .epb_rdy_o  (epb_rdy_o)
  );

  wb_slave_decode wb_slave_decode_i (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .req_i         (bridge_req),
    .regbank_req_o (regbank_req),
    .idblock_req_o (idblock_req),
    .regbank_rsp_i (regbank_rsp),
    .idblock_rsp_i (idblock_rsp),
    .rsp_o         (bridge_rsp)
  );

  wb_reg_bank wb_reg_bank_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .req_i    (regbank_req),
    .rsp_o    (regbank_rsp)
  );

  wb_id_block wb_id_block_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .req_i    (idblock_req),
    .rsp_o    (idblock_rsp)
  );

endmodule

// ==== tb_epb_subsystem.sv ====
`timescale 1ns/1ps
`include "epb_config.svh"

module tb_epb_subsystem;

  // limit for every wait on epb_rdy_o in epb_clk_i cycles
  localparam int TIMEOUT_CYCLES = 200;
  localparam int BANK_WORDS     = 1 << `REG_BANK_ADDR_BITS;
  // group with no slave behind it
  localparam epb_pkg::epb_gp_t GP_UNMAPPED = 6'd9;

  logic               wb_clk_i;
  logic               wb_rst_i;
  logic               epb_clk_i;
  logic               epb_cs_n_i;
  logic               epb_oe_n_i;
  epb_pkg::epb_cmd_t  epb_cmd_i;
  epb_pkg::epb_data_t epb_data_o;
  logic               epb_rdy_o;

  logic [31:0]        lfsr_state;
  int                 err_cnt;
  int                 chk_cnt;
  int                 test_cnt;
  // expected bank contents
  epb_pkg::epb_data_t bank_exp [BANK_WORDS];

  epb_subsystem_top epb_subsystem_top_i (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .epb_clk_i  (epb_clk_i),
    .epb_cs_n_i (epb_cs_n_i),
    .epb_oe_n_i (epb_oe_n_i),
    .epb_cmd_i  (epb_cmd_i),
    .epb_data_o (epb_data_o),
    .epb_rdy_o  (epb_rdy_o)
  );

  // wishbone clock with a 100 ns period
  always #50 wb_clk_i = ~wb_clk_i;
  // EPB clock with a 130 ns period
  // its rising edges sit on odd 5 ns steps and never meet a wb edge
  always #65 epb_clk_i = ~epb_clk_i;

  // galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per data bit
  function automatic epb_pkg::epb_data_t rand_word();
    epb_pkg::epb_data_t w;
    for (int i = 0; i < 16; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // one EPB transfer that returns whatever epb_data_o shows once ready is seen
  task automatic run_transfer(input epb_pkg::epb_cmd_t cmd, output epb_pkg::epb_data_t rd_data);
    int n;
    @(posedge epb_clk_i);
    epb_cmd_i  <= cmd;
    epb_oe_n_i <= ~cmd.rd_wr_n;
    @(posedge epb_clk_i);
    epb_cs_n_i <= 1'b0;
    // ready of the previous transfer drops first
    n = 0;
    do begin
      @(posedge epb_clk_i);
      n++;
    end while (epb_rdy_o && n < TIMEOUT_CYCLES);
    if (epb_rdy_o) begin
      $display("ready stayed high after chip select went low, group %0d word %0h",
               cmd.gp, cmd.addr);
      err_cnt++;
    end
    n = 0;
    while (!epb_rdy_o && n < TIMEOUT_CYCLES) begin
      @(posedge epb_clk_i);
      n++;
    end
    if (!epb_rdy_o) begin
      $display("transfer timed out waiting for ready, group %0d word %0h", cmd.gp, cmd.addr);
      err_cnt++;
    end
    rd_data = epb_data_o;
    epb_cs_n_i <= 1'b1;
    epb_oe_n_i <= 1'b1;
  endtask

  task automatic epb_write(input epb_pkg::epb_gp_t gp, input epb_pkg::epb_addr_t addr,
                           input epb_pkg::epb_be_t be_n, input epb_pkg::epb_data_t data);
    epb_pkg::epb_cmd_t  cmd;
    epb_pkg::epb_data_t ignored;
    cmd.rd_wr_n = 1'b0;
    cmd.be_n    = be_n;
    cmd.gp      = gp;
    cmd.addr    = addr;
    cmd.data    = data;
    run_transfer(cmd, ignored);
  endtask

  task automatic epb_read(input epb_pkg::epb_gp_t gp, input epb_pkg::epb_addr_t addr,
                          output epb_pkg::epb_data_t data);
    epb_pkg::epb_cmd_t cmd;
    cmd.rd_wr_n = 1'b1;
    cmd.be_n    = 2'b00;
    cmd.gp      = gp;
    cmd.addr    = addr;
    cmd.data    = '0;
    run_transfer(cmd, data);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: %0d failures", name, err_cnt - errs_before);
    end
  endtask

  task automatic test_reset_read();
    int                 errs_before;
    epb_pkg::epb_data_t d;
    errs_before = err_cnt;
    check_val("epb_rdy_o", 16'(epb_rdy_o), 16'h0000);
    epb_read(`EPB_GP_REGBANK, 23'd0, d);
    check_val("epb_data_o", d, 16'h0000);
    finish_test("reset_read", errs_before);
  endtask

  task automatic test_full_words();
    int                 errs_before;
    epb_pkg::epb_data_t d;
    errs_before = err_cnt;
    for (int i = 0; i < BANK_WORDS; i++) begin
      bank_exp[i] = rand_word();
      epb_write(`EPB_GP_REGBANK, 23'(i), 2'b00, bank_exp[i]);
    end
    for (int i = 0; i < BANK_WORDS; i++) begin
      epb_read(`EPB_GP_REGBANK, 23'(i), d);
      check_val("epb_data_o", d, bank_exp[i]);
    end
    finish_test("full_words", errs_before);
  endtask

  task automatic test_byte_lanes();
    int                 errs_before;
    epb_pkg::epb_data_t w;
    epb_pkg::epb_data_t d;
    errs_before = err_cnt;
    // be_n is active low so this writes the low byte only
    w = rand_word();
    epb_write(`EPB_GP_REGBANK, 23'd3, 2'b10, w);
    bank_exp[3] = {bank_exp[3][15:8], w[7:0]};
    // high byte only
    w = rand_word();
    epb_write(`EPB_GP_REGBANK, 23'd7, 2'b01, w);
    bank_exp[7] = {w[15:8], bank_exp[7][7:0]};
    epb_read(`EPB_GP_REGBANK, 23'd3, d);
    check_val("epb_data_o", d, bank_exp[3]);
    epb_read(`EPB_GP_REGBANK, 23'd7, d);
    check_val("epb_data_o", d, bank_exp[7]);
    // word 19 lands on word 3
    epb_read(`EPB_GP_REGBANK, 23'(BANK_WORDS + 3), d);
    check_val("epb_data_o", d, bank_exp[3]);
    finish_test("byte_lanes", errs_before);
  endtask

  task automatic test_id_words();
    int                 errs_before;
    epb_pkg::epb_data_t d;
    errs_before = err_cnt;
    epb_read(`EPB_GP_IDBLOCK, 23'd0, d);
    check_val("epb_data_o", d, `BOARD_ID);
    epb_read(`EPB_GP_IDBLOCK, 23'd1, d);
    check_val("epb_data_o", d, `FW_REVISION);
    // nothing rejected so far
    epb_read(`EPB_GP_IDBLOCK, 23'd2, d);
    check_val("epb_data_o", d, 16'h0000);
    finish_test("id_words", errs_before);
  endtask

  task automatic test_errors();
    int                 errs_before;
    epb_pkg::epb_data_t d;
    epb_pkg::epb_data_t rejects;
    errs_before = err_cnt;
    rejects = '0;
    // refused writes that the ID block counts
    epb_write(`EPB_GP_IDBLOCK, 23'd0, 2'b00, rand_word());
    rejects++;
    epb_write(`EPB_GP_IDBLOCK, 23'd5, 2'b00, rand_word());
    rejects++;
    epb_write(`EPB_GP_IDBLOCK, 23'd1, 2'b10, rand_word());
    rejects++;
    // unmapped group gets err from the decoder and no count
    epb_write(GP_UNMAPPED, 23'd0, 2'b00, rand_word());
    epb_read(`EPB_GP_IDBLOCK, 23'd2, d);
    check_val("epb_data_o", d, rejects);
    // board ID differs from the counter the ID block puts on dat for word 5
    epb_read(`EPB_GP_IDBLOCK, 23'd0, d);
    check_val("epb_data_o", d, `BOARD_ID);
    // error reads leave the last read data in place
    epb_read(`EPB_GP_IDBLOCK, 23'd5, d);
    check_val("epb_data_o", d, `BOARD_ID);
    epb_read(GP_UNMAPPED, 23'd2, d);
    check_val("epb_data_o", d, `BOARD_ID);
    finish_test("errors", errs_before);
  endtask

  task automatic test_back_to_back();
    int                 errs_before;
    epb_pkg::epb_data_t exp_q [$];
    epb_pkg::epb_data_t w;
    epb_pkg::epb_data_t d;
    errs_before = err_cnt;
    // each transfer starts right after the previous ready
    for (int i = BANK_WORDS / 2; i < BANK_WORDS; i++) begin
      w = rand_word();
      bank_exp[i] = w;
      exp_q.push_back(w);
      epb_write(`EPB_GP_REGBANK, 23'(i), 2'b00, w);
      epb_read(`EPB_GP_REGBANK, 23'(i), d);
      check_val("epb_data_o", d, w);
    end
    // sweep again in write order
    for (int i = BANK_WORDS / 2; i < BANK_WORDS; i++) begin
      epb_read(`EPB_GP_REGBANK, 23'(i), d);
      check_val("epb_data_o", d, exp_q.pop_front());
    end
    finish_test("back_to_back", errs_before);
  endtask

  initial begin
    wb_clk_i   = 1'b0;
    epb_clk_i  = 1'b0;
    wb_rst_i   = 1'b1;
    epb_cs_n_i = 1'b1;
    epb_oe_n_i = 1'b1;
    epb_cmd_i  = '0;
    lfsr_state = 32'hd5ca7995;
    err_cnt    = 0;
    chk_cnt    = 0;
    test_cnt   = 0;
    // long enough to clear the EPB side flags too
    repeat (16) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    repeat (2) @(posedge wb_clk_i);

    test_reset_read();
    test_full_words();
    test_byte_lanes();
    test_id_words();
    test_errors();
    test_back_to_back();

    $display("%0d tests, %0d checks, %0d failures", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
epb_pkg.sv
wb_pkg.sv
epb_wb_bridge_reg.sv
wb_slave_decode.sv
wb_reg_bank.sv
wb_id_block.sv
epb_subsystem_top.sv
tb_epb_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the EPB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal -f all.f --top-module tb_epb_subsystem -o sim_epb
./obj_dir/sim_epb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation passed"
